//--- logic/bus_macros.svh
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// BIOS on-chip RAM depth in 16-bit words.
`define BIOS_WORDS 4096

// Main RAM depth in words, aliased above this size.
`define MAIN_RAM_WORDS 4096

// Cycles from first chip select to the main RAM ack.
`define MAIN_RAM_WAIT 3

// Address bits 19:13 all set selects the BIOS region.
`define BIOS_BASE_BITS 7'h7f

// I/O byte addresses.
`define IO_CONFIG_ADDR 16'hfffc
`define IO_SCRATCH_ADDR 16'hfffa

`endif

//--- logic/bus_pkg.sv
package bus_pkg;

    // One bus request, held by the master until it sees ack.
    typedef struct packed {
        logic        access;  // Access in progress.
        logic        wr_en;   // Write when set.
        logic [1:0]  bytesel; // Upper and lower byte lanes.
        logic [19:1] addr;    // Word address.
        logic [15:0] wdata;
    } bus_req_t;

    // Response; an idle target drives all zeros so responses can be ORed.
    typedef struct packed {
        logic        ack;   // One cycle pulse.
        logic [15:0] rdata; // Valid with ack only.
    } bus_rsp_t;

endpackage

//--- logic/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter import bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  bus_req_t instr_req,
    input  bus_req_t data_req,
    input  bus_rsp_t mem_rsp,
    output bus_rsp_t instr_rsp,
    output bus_rsp_t data_rsp,
    output bus_req_t mem_req
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INSTR,
        ARB_DATA
    } arb_state_t;

    arb_state_t state;
    arb_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                // Data side has fixed priority.
                if (data_req.access) begin
                    state_next = ARB_DATA;
                end else if (instr_req.access) begin
                    state_next = ARB_INSTR;
                end
            end
            ARB_INSTR, ARB_DATA: begin
                if (mem_rsp.ack) begin
                    state_next = ARB_IDLE; // Target done.
                end
            end
            default: begin
                state_next = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Granted request goes out as is; the response only returns to its owner.
    always_comb begin
        mem_req   = '0;
        instr_rsp = '0;
        data_rsp  = '0;
        case (state)
            ARB_INSTR: begin
                mem_req   = instr_req;
                instr_rsp = mem_rsp;
            end
            ARB_DATA: begin
                mem_req  = data_req;
                data_rsp = mem_rsp;
            end
            default: begin
                mem_req = '0; // Bus quiet while idle.
            end
        endcase
    end

endmodule

//--- logic/bios_ram.sv
`timescale 1ns/100ps
`include "bus_macros.svh"

module bios_ram import bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cs,
    input  bus_req_t req,
    output bus_rsp_t rsp
);

    localparam int ADDR_BITS = $clog2(`BIOS_WORDS);

    logic [15:0] mem [`BIOS_WORDS];

    logic                 busy;
    logic                 fire;
    logic [ADDR_BITS-1:0] word_addr;
    logic [15:0]          rdata_q;

    assign word_addr = req.addr[ADDR_BITS:1];
    assign fire      = cs && !busy; // One access per request.

    // Array itself.
    always_ff @(posedge clk) begin
        if (fire && req.wr_en) begin
            if (req.bytesel[0]) begin
                mem[word_addr][7:0] <= req.wdata[7:0];
            end
            if (req.bytesel[1]) begin
                mem[word_addr][15:8] <= req.wdata[15:8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy    <= 1'b0;
            rdata_q <= '0;
        end else begin
            busy <= fire; // Doubles as the ack.
            if (fire && !req.wr_en) begin
                rdata_q <= mem[word_addr];
            end else begin
                rdata_q <= '0; // Keep the OR bus clean.
            end
        end
    end

    assign rsp.ack   = busy;
    assign rsp.rdata = rdata_q;

endmodule

//--- logic/main_ram.sv
`timescale 1ns/100ps
`include "bus_macros.svh"

module main_ram import bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     cs,
    input  bus_req_t req,
    output bus_rsp_t rsp
);

    localparam int ADDR_BITS = $clog2(`MAIN_RAM_WORDS);
    localparam int CNT_BITS  = $clog2(`MAIN_RAM_WAIT + 1);
    localparam logic [CNT_BITS-1:0] LAST_CNT = CNT_BITS'(`MAIN_RAM_WAIT - 1);

    logic [15:0] mem [`MAIN_RAM_WORDS];

    logic [CNT_BITS-1:0]  wait_cnt;
    logic                 ack_q;
    logic                 fire;
    logic [ADDR_BITS-1:0] word_addr;
    logic [15:0]          rdata_q;

    // Upper address bits are ignored so the array aliases.
    assign word_addr = req.addr[ADDR_BITS:1];

    // Access happens on the last wait cycle.
    assign fire = cs && !ack_q && (wait_cnt == LAST_CNT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (cs && !ack_q) begin
                if (wait_cnt == LAST_CNT) begin
                    wait_cnt <= '0;
                    ack_q    <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end else begin
                // Request still up during the ack, so skip it.
                wait_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && req.wr_en) begin
            if (req.bytesel[0]) begin
                mem[word_addr][7:0] <= req.wdata[7:0];
            end
            if (req.bytesel[1]) begin
                mem[word_addr][15:8] <= req.wdata[15:8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata_q <= '0;
        end else if (fire && !req.wr_en) begin
            rdata_q <= mem[word_addr];
        end else begin
            rdata_q <= '0;
        end
    end

    assign rsp.ack   = ack_q;
    assign rsp.rdata = rdata_q;

endmodule

//--- logic/io_block.sv
`timescale 1ns/100ps
`include "bus_macros.svh"

module io_block import bus_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        d_io,
    input  bus_req_t    req,
    output bus_rsp_t    rsp,
    output logic [15:0] mem_config
);

    logic [15:0] io_addr;
    logic        sel;
    logic        hit_config;
    logic        hit_scratch;
    logic        ack_q;
    logic [15:0] rdata_q;
    logic [15:0] config_q;
    logic [15:0] scratch_q;
    logic [15:0] read_val;

    // I/O space is 16-bit byte addressed.
    assign io_addr = {req.addr[15:1], 1'b0};

    assign sel         = d_io && req.access && !ack_q; // One ack per access.
    assign hit_config  = (io_addr == `IO_CONFIG_ADDR);
    assign hit_scratch = (io_addr == `IO_SCRATCH_ADDR);

    always_comb begin
        if (hit_config) begin
            read_val = config_q;
        end else if (hit_scratch) begin
            read_val = scratch_q;
        end else begin
            read_val = '0; // Unmapped reads as zero.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            config_q  <= '0;
            scratch_q <= '0;
        end else if (sel && req.wr_en) begin
            if (hit_config && req.bytesel[0]) begin
                config_q[7:0] <= req.wdata[7:0];
            end
            if (hit_config && req.bytesel[1]) begin
                config_q[15:8] <= req.wdata[15:8];
            end
            if (hit_scratch && req.bytesel[0]) begin
                scratch_q[7:0] <= req.wdata[7:0];
            end
            if (hit_scratch && req.bytesel[1]) begin
                scratch_q[15:8] <= req.wdata[15:8];
            end
        end
    end

    // Every I/O address gets an ack, mapped or not.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            ack_q <= sel;
            if (sel && !req.wr_en) begin
                rdata_q <= read_val;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign rsp.ack    = ack_q;
    assign rsp.rdata  = rdata_q;
    assign mem_config = config_q; // To a later memory controller.

endmodule

//--- logic/bus_subsystem.sv
`timescale 1ns/100ps
`include "bus_macros.svh"

module bus_subsystem import bus_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  bus_req_t    instr_req,
    input  bus_req_t    data_req,
    input  logic        d_io,
    output bus_rsp_t    instr_rsp,
    output bus_rsp_t    data_rsp,
    output logic [15:0] mem_config
);

    bus_req_t arb_data_req;
    bus_rsp_t arb_data_rsp;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;
    bus_rsp_t bios_rsp;
    bus_rsp_t main_rsp;
    bus_rsp_t io_rsp;
    logic     bios_hit;
    logic     bios_cs;
    logic     main_cs;

    // I/O accesses never reach the arbiter.
    assign arb_data_req = '{
        access:  data_req.access & ~d_io,
        wr_en:   data_req.wr_en,
        bytesel: data_req.bytesel,
        addr:    data_req.addr,
        wdata:   data_req.wdata
    };

    // Region decode on the shared memory bus.
    assign bios_hit = (mem_req.addr[19:13] == `BIOS_BASE_BITS);
    assign bios_cs  = mem_req.access && bios_hit;
    assign main_cs  = mem_req.access && !bios_hit;

    assign mem_rsp  = bios_rsp | main_rsp;     // Idle targets drive zero.
    assign data_rsp = arb_data_rsp | io_rsp;

    mem_arbiter u_mem_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr_req (instr_req),
        .data_req  (arb_data_req),
        .mem_rsp   (mem_rsp),
        .instr_rsp (instr_rsp),
        .data_rsp  (arb_data_rsp),
        .mem_req   (mem_req)
    );

    bios_ram u_bios_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (bios_cs),
        .req    (mem_req),
        .rsp    (bios_rsp)
    );

    main_ram u_main_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (main_cs),
        .req    (mem_req),
        .rsp    (main_rsp)
    );

    io_block u_io_block (
        .clk        (clk),
        .arst_n     (arst_n),
        .d_io       (d_io),
        .req        (data_req),
        .rsp        (io_rsp),
        .mem_config (mem_config)
    );

endmodule

//--- dv/bus_tb.sv
`timescale 1ns/100ps

module bus_tb import bus_pkg::*; ();

    localparam int NUM_PATS = 26;
    localparam int FIELDS   = 7;

    logic        clk;
    logic        arst_n;
    bus_req_t    instr_req;
    bus_req_t    data_req;
    logic        d_io;
    bus_rsp_t    instr_rsp;
    bus_rsp_t    data_rsp;
    logic [15:0] mem_config;

    logic [19:0] pat [NUM_PATS*FIELDS];
    logic [15:0] shadow [int];   // Memory model keyed by region and word.
    logic [15:0] config_model;
    logic [31:0] rng;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    bus_subsystem u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_req  (instr_req),
        .data_req   (data_req),
        .d_io       (d_io),
        .instr_rsp  (instr_rsp),
        .data_rsp   (data_rsp),
        .mem_config (mem_config)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run reached %0d cycles while waiting for an ack.",
                     cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic bus_req_t make_req(input int idx);
        make_req = '{
            access:  1'b1,
            wr_en:   pat[idx*FIELDS+1][0],
            bytesel: pat[idx*FIELDS+2][1:0],
            addr:    pat[idx*FIELDS+3][19:1],
            wdata:   pat[idx*FIELDS+4][15:0]
        };
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old_val,
                                                input logic [15:0] new_val,
                                                input logic [1:0]  sel);
        merge_bytes = old_val;
        if (sel[0]) merge_bytes[7:0] = new_val[7:0];
        if (sel[1]) merge_bytes[15:8] = new_val[15:8];
    endfunction

    function automatic int mem_key(input logic [19:0] addr);
        logic bios;
        bios = (addr[19:13] == 7'h7f); // Top of the address space.
        return {bios, addr[12:1]};     // Both arrays alias above 4096 words.
    endfunction

    function automatic string bus_name(input logic [1:0] bus);
        case (bus)
            2'd0:    return "instr";
            2'd1:    return "data-mem";
            default: return "data-io";
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    // Checks one acked transaction and updates the models.
    task automatic finish_check(input int idx, input logic [15:0] got, input string name);
        logic [1:0]  bus;
        logic        wr;
        logic [1:0]  sel;
        logic [19:0] addr;
        logic [15:0] wdata;
        int          key;
        bus   = pat[idx*FIELDS][1:0];
        wr    = pat[idx*FIELDS+1][0];
        sel   = pat[idx*FIELDS+2][1:0];
        addr  = pat[idx*FIELDS+3];
        wdata = pat[idx*FIELDS+4][15:0];
        key   = mem_key(addr);
        compare_word(name, got, pat[idx*FIELDS+5][15:0]);
        if (bus != 2'd2) begin
            if (wr) begin
                if (!shadow.exists(key)) shadow[key] = 16'hxxxx;
                shadow[key] = merge_bytes(shadow[key], wdata, sel);
            end else if (shadow.exists(key) && !$isunknown(shadow[key])) begin
                compare_word(name, got, shadow[key]);
            end
        end else if (wr) begin
            if ({addr[15:1], 1'b0} == 16'hfffc) begin
                config_model = merge_bytes(config_model, wdata, sel);
            end
            compare_word("mem_config", mem_config, config_model);
        end
    endtask

    // Issues a data and/or instr request (-1 when absent) and waits for the acks.
    task automatic run_transaction(input int d_idx, input int i_idx);
        int   d_acks;
        int   i_acks;
        logic d_done;
        logic i_done;
        logic d_hit;
        logic i_hit;
        d_acks = 0;
        i_acks = 0;
        d_done = (d_idx < 0);
        i_done = (i_idx < 0);
        @(posedge clk);
        if (d_idx >= 0) begin
            data_req <= make_req(d_idx);
            d_io     <= (pat[d_idx*FIELDS][1:0] == 2'd2);
        end
        if (i_idx >= 0) instr_req <= make_req(i_idx);
        while (!(d_done && i_done)) begin
            @(negedge clk);
            d_hit = data_rsp.ack && !d_done;
            i_hit = instr_rsp.ack && !i_done;
            if (data_rsp.ack) d_acks++;
            if (instr_rsp.ack) i_acks++;
            if (d_hit) finish_check(d_idx, data_rsp.rdata, "data_rsp.rdata");
            if (i_hit) finish_check(i_idx, instr_rsp.rdata, "instr_rsp.rdata");
            @(posedge clk);
            if (d_hit) begin
                data_req <= '0;
                d_io     <= 1'b0;
                d_done = 1'b1;
            end
            if (i_hit) begin
                instr_req <= '0;
                i_done = 1'b1;
            end
        end
        @(negedge clk); // Catches a stray second ack.
        if (data_rsp.ack) d_acks++;
        if (instr_rsp.ack) i_acks++;
        assert (d_acks == int'(d_idx >= 0)) else begin
            $display("Data bus gave %0d acks at %0t where one per request was due.",
                     d_acks, $time);
            error_count++;
        end
        assert (i_acks == int'(i_idx >= 0)) else begin
            $display("Instr bus gave %0d acks at %0t where one per request was due.",
                     i_acks, $time);
            error_count++;
        end
    endtask

    task automatic report_test(input string label, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s: ok", label);
        end else begin
            fail_count++;
            $display("%s: failed", label);
        end
    endtask

    initial begin
        int idx;
        int errors_before;
        rng          = 32'hfc9c;
        arst_n       = 1'b0;
        instr_req    = '0;
        data_req     = '0;
        d_io         = 1'b0;
        config_model = '0;
        $readmemh("dv/bus_patterns.txt", pat);
        cycle_limit = NUM_PATS * 16 + 50;
        assert (!$isunknown(pat[NUM_PATS*FIELDS-1])) else begin
            $display("Pattern file holds fewer transactions than expected.");
            error_count++;
        end

        errors_before = error_count;
        @(negedge clk);
        compare_word("instr_rsp.ack", 16'(instr_rsp.ack), 16'h0);
        compare_word("data_rsp.ack", 16'(data_rsp.ack), 16'h0);
        compare_word("mem_config", mem_config, 16'h0);
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        compare_word("instr_rsp.ack", 16'(instr_rsp.ack), 16'h0);
        compare_word("data_rsp.ack", 16'(data_rsp.ack), 16'h0);
        compare_word("mem_config", mem_config, 16'h0);
        report_test("test reset", errors_before);

        idx = 0;
        while (idx < NUM_PATS) begin
            errors_before = error_count;
            if (pat[idx*FIELDS+6][0] && idx + 1 < NUM_PATS) begin
                run_transaction(idx, idx + 1);
                report_test($sformatf("test %0d %s with instr", idx,
                                      bus_name(pat[idx*FIELDS][1:0])), errors_before);
                idx += 2;
            end else begin
                if (pat[idx*FIELDS][1:0] == 2'd0) begin
                    run_transaction(-1, idx);
                end else begin
                    run_transaction(idx, -1);
                end
                report_test($sformatf("test %0d %s", idx,
                                      bus_name(pat[idx*FIELDS][1:0])), errors_before);
                idx += 1;
            end
            rng = xorshift32(rng);
            repeat (rng[1:0]) @(posedge clk); // Idle gap of 0 to 3 cycles.
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+logic
logic/bus_pkg.sv
logic/mem_arbiter.sv
logic/bios_ram.sv
logic/main_ram.sv
logic/io_block.sv
logic/bus_subsystem.sv
dv/bus_tb.sv

//--- dv/bus_patterns.txt
// bus (0 instr, 1 data-mem, 2 data-io) wr bytesel byte_addr wdata expected_rdata pair
// A pair flag of 1 issues this data line together with the next line on the instr bus.
1 1 3 00010 a5c3 0000 0
1 0 3 00010 0000 a5c3 0
1 1 1 00010 0011 0000 0
1 1 2 00010 7700 0000 0
1 0 3 00010 0000 7711 0
1 1 3 fe010 c0de 0000 0
1 1 3 ffffe 0bad 0000 0
0 0 3 fe010 0000 c0de 0
0 0 3 ffffe 0000 0bad 0
2 1 3 0fffc 5a5a 0000 0
2 0 3 0fffc 0000 5a5a 0
2 1 2 0fffc ff00 0000 0
2 0 3 0fffc 0000 ff5a 0
2 1 3 0fffa 1357 0000 0
2 0 3 0fffa 0000 1357 0
2 0 3 0fff0 0000 0000 0
1 0 3 00010 0000 7711 1
0 0 3 fe010 0000 c0de 0
1 1 3 00040 2468 0000 1
0 0 3 ffffe 0000 0bad 0
2 0 3 0fffa 0000 1357 1
0 0 3 00010 0000 7711 0
1 1 3 00100 1234 0000 0
2 1 3 00100 beef 0000 0
1 0 3 00100 0000 1234 0
1 0 3 00040 0000 2468 0
